// ==== common/aluPkg.sv ====
// Shared definitions for the integer execute subsystem
// Instruction field widths, primary opcode and funct encodings,
// and the internal operation set used between decoder and ALU

package aluPkg;

    //////////////////////////////
    // Field widths
    //////////////////////////////

    parameter int DataWidth    = 32;
    parameter int InstrWidth   = 32;
    parameter int RegAddrWidth = 5;
    parameter int OpcodeWidth  = 6;
    parameter int FunctWidth   = 6;
    parameter int ShamtWidth   = 5;
    parameter int ImmWidth     = 16;

    //////////////////////////////
    // Instruction encodings
    //////////////////////////////

    // Primary opcode, bits 31..26
    typedef enum logic [OpcodeWidth-1:0] {
        OPC_SPECIAL = 6'h00,
        OPC_ADDIU   = 6'h09,
        OPC_SLTI    = 6'h0A,
        OPC_ORI     = 6'h0D,
        OPC_LUI     = 6'h0F
    } opcodeE;

    // Funct field of the SPECIAL group, bits 5..0
    typedef enum logic [FunctWidth-1:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_SLLV = 6'h04,
        FN_SRLV = 6'h06,
        FN_SRAV = 6'h07,
        FN_JR   = 6'h08,
        FN_JALR = 6'h09,
        FN_MOVZ = 6'h0A,
        FN_MOVN = 6'h0B,
        FN_ADD  = 6'h20,
        FN_ADDU = 6'h21,
        FN_SUB  = 6'h22,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2A,
        FN_SLTU = 6'h2B
    } functE;

    //////////////////////////////
    // Internal ALU operations
    //////////////////////////////

    // OP_NOP marks an illegal or unsupported instruction
    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADD,
        OP_ADDU,
        OP_SUB,
        OP_SUBU,
        OP_SLL,
        OP_SLLV,
        OP_SRA,
        OP_SRAV,
        OP_SRL,
        OP_SRLV,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_MOVN,
        OP_MOVZ,
        OP_SLT,
        OP_SLTU,
        OP_ADDIU,
        OP_ORI,
        OP_LUI,
        OP_SLTI
    } aluOpE;

endpackage

// ==== hw/decode/operandDecode.sv ====
// Operand decoder
// Splits each instruction word into fields, maps it to an ALU operation,
// reads both operands with a bypass from write-back and registers the result

`timescale 1ns/1ps

module operandDecode
(
    input  logic                             clk,
    input  logic                             arstN,
    input  logic                             instrValid,
    input  logic [aluPkg::InstrWidth-1:0]    instr,
    input  logic [aluPkg::DataWidth-1:0]     rsData,
    input  logic [aluPkg::DataWidth-1:0]     rtData,
    input  logic                             wbEn,
    input  logic [aluPkg::RegAddrWidth-1:0]  wbAddr,
    input  logic [aluPkg::DataWidth-1:0]     wbData,
    output logic [aluPkg::RegAddrWidth-1:0]  rsAddr,
    output logic [aluPkg::RegAddrWidth-1:0]  rtAddr,
    output logic                             opValid,
    output aluPkg::aluOpE                    op,
    output logic [aluPkg::DataWidth-1:0]     opA,
    output logic [aluPkg::DataWidth-1:0]     opB,
    output logic [aluPkg::ShamtWidth-1:0]    shamt,
    output logic [aluPkg::RegAddrWidth-1:0]  destReg
);
    import aluPkg::*;

    logic [OpcodeWidth-1:0]  opcodeField;
    logic [RegAddrWidth-1:0] rdField;
    logic [ShamtWidth-1:0]   shamtField;
    logic [FunctWidth-1:0]   functField;
    logic [ImmWidth-1:0]     immField;
    aluOpE                   decOp;
    logic                    isIType;
    logic [DataWidth-1:0]    rsVal;
    logic [DataWidth-1:0]    rtVal;
    logic [DataWidth-1:0]    bVal;

    //////////////////////////////
    // Field split
    //////////////////////////////

    assign opcodeField = instr[31:26];
    assign rsAddr      = instr[25:21];
    assign rtAddr      = instr[20:16];
    assign rdField     = instr[15:11];
    assign shamtField  = instr[10:6];
    assign functField  = instr[5:0];
    assign immField    = instr[15:0];

    // Opcode and funct to internal operation
    always_comb
    begin
        decOp   = OP_NOP;
        isIType = 1'b0;
        case (opcodeE'(opcodeField))
            OPC_SPECIAL:
            begin
                case (functE'(functField))
                    FN_ADD:  decOp = OP_ADD;
                    FN_ADDU: decOp = OP_ADDU;
                    FN_SUB:  decOp = OP_SUB;
                    FN_SUBU: decOp = OP_SUBU;
                    FN_SLL:  decOp = OP_SLL;
                    FN_SLLV: decOp = OP_SLLV;
                    FN_SRA:  decOp = OP_SRA;
                    FN_SRAV: decOp = OP_SRAV;
                    FN_SRL:  decOp = OP_SRL;
                    FN_SRLV: decOp = OP_SRLV;
                    FN_AND:  decOp = OP_AND;
                    FN_OR:   decOp = OP_OR;
                    FN_XOR:  decOp = OP_XOR;
                    FN_NOR:  decOp = OP_NOR;
                    FN_MOVN: decOp = OP_MOVN;
                    FN_MOVZ: decOp = OP_MOVZ;
                    FN_SLT:  decOp = OP_SLT;
                    FN_SLTU: decOp = OP_SLTU;
                    // Jumps are not executed here
                    FN_JR:   decOp = OP_NOP;
                    FN_JALR: decOp = OP_NOP;
                    default: decOp = OP_NOP;
                endcase
            end
            OPC_ADDIU:
            begin
                decOp   = OP_ADDIU;
                isIType = 1'b1;
            end
            OPC_SLTI:
            begin
                decOp   = OP_SLTI;
                isIType = 1'b1;
            end
            OPC_ORI:
            begin
                decOp   = OP_ORI;
                isIType = 1'b1;
            end
            OPC_LUI:
            begin
                decOp   = OP_LUI;
                isIType = 1'b1;
            end
            default:
                decOp = OP_NOP;
        endcase
    end

    //////////////////////////////
    // Operand select
    //////////////////////////////

    // Result still in flight from the ALU wins over the register file
    assign rsVal = (wbEn && (wbAddr != '0) && (wbAddr == rsAddr)) ? wbData : rsData;
    assign rtVal = (wbEn && (wbAddr != '0) && (wbAddr == rtAddr)) ? wbData : rtData;

    always_comb
    begin
        case (decOp)
            OP_ADDIU,
            OP_SLTI:
                bVal = {{(DataWidth-ImmWidth){immField[ImmWidth-1]}}, immField};
            OP_ORI:
                bVal = {{(DataWidth-ImmWidth){1'b0}}, immField};
            OP_LUI:
                bVal = {immField, {(DataWidth-ImmWidth){1'b0}}};
            default:
                bVal = rtVal;
        endcase
    end

    // Decode stage register
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            opValid <= 1'b0;
            op      <= OP_NOP;
        end
        else
        begin
            opValid <= instrValid;
            if (instrValid)
                op <= decOp;
        end
    end

    always_ff @(posedge clk)
    begin
        if (instrValid)
        begin
            opA     <= rsVal;
            opB     <= bVal;
            shamt   <= shamtField;
            destReg <= isIType ? rtAddr : rdField;
        end
    end

    // Accepted instruction words must be fully driven
    assert property (@(posedge clk) disable iff (!arstN) instrValid |-> !$isunknown(instr))
        else $error("Instruction word has unknown bits while instrValid is high");

endmodule

// ==== hw/regFile.sv ====
// General purpose register file
// 32 words of 32 bits, register 0 hardwired to zero,
// two combinational read ports and one write port

`timescale 1ns/1ps

module regFile
(
    input  logic                             clk,
    input  logic                             arstN,
    input  logic [aluPkg::RegAddrWidth-1:0]  rsAddr,
    input  logic [aluPkg::RegAddrWidth-1:0]  rtAddr,
    input  logic                             wbEn,
    input  logic [aluPkg::RegAddrWidth-1:0]  wbAddr,
    input  logic [aluPkg::DataWidth-1:0]     wbData,
    output logic [aluPkg::DataWidth-1:0]     rsData,
    output logic [aluPkg::DataWidth-1:0]     rtData
);
    import aluPkg::*;

    // Only registers 1..31 hold state
    logic [DataWidth-1:0] regs [1:(1<<RegAddrWidth)-1];

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 1; i < (1 << RegAddrWidth); i++)
                regs[i] <= '0;
        end
        else if (wbEn && (wbAddr != '0))
        begin
            regs[wbAddr] <= wbData;
        end
    end

    // Reads see the old value during a write, the decoder bypass covers that
    assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
    assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

    assert property (@(posedge clk) disable iff (!arstN) wbEn |-> !$isunknown(wbAddr))
        else $error("Write-back address unknown while wbEn is high");

endmodule

// ==== hw/alu/alu.sv ====
// Integer ALU
// Executes one decoded operation per cycle, derives the flags and the
// write-back enable, and registers the result for the outside

`timescale 1ns/1ps

module alu
(
    input  logic                             clk,
    input  logic                             arstN,
    input  logic                             opValid,
    input  aluPkg::aluOpE                    op,
    input  logic [aluPkg::DataWidth-1:0]     opA,
    input  logic [aluPkg::DataWidth-1:0]     opB,
    input  logic [aluPkg::ShamtWidth-1:0]    shamt,
    input  logic [aluPkg::RegAddrWidth-1:0]  destReg,
    output logic                             wbEn,
    output logic [aluPkg::RegAddrWidth-1:0]  wbAddr,
    output logic [aluPkg::DataWidth-1:0]     wbData,
    output logic                             resultValid,
    output logic [aluPkg::DataWidth-1:0]     resultData,
    output logic [aluPkg::RegAddrWidth-1:0]  resultReg,
    output logic                             written,
    output logic                             illegal,
    output logic                             carry,
    output logic                             zero,
    output logic                             overflow,
    output logic                             negative
);
    import aluPkg::*;

    logic [DataWidth:0]    sum;
    logic [DataWidth:0]    diff;
    logic [DataWidth-1:0]  res;
    logic                  carryC;
    logic                  ovfC;
    logic                  moveOk;
    logic                  isNop;
    logic                  zeroC;
    logic                  negC;

    //////////////////////////////
    // Execute
    //////////////////////////////

    // 33-bit forms give carry and borrow directly
    assign sum   = {1'b0, opA} + {1'b0, opB};
    assign diff  = {1'b0, opA} - {1'b0, opB};
    assign isNop = (op == OP_NOP);

    always_comb
    begin
        res    = '0;
        carryC = 1'b0;
        ovfC   = 1'b0;
        moveOk = 1'b1;
        case (op)
            OP_ADD:
            begin
                res    = sum[DataWidth-1:0];
                carryC = sum[DataWidth];
                ovfC   = (opA[DataWidth-1] == opB[DataWidth-1]) &&
                         (sum[DataWidth-1] != opA[DataWidth-1]);
            end
            OP_ADDU,
            OP_ADDIU:
            begin
                res    = sum[DataWidth-1:0];
                carryC = sum[DataWidth];
            end
            OP_SUB:
            begin
                res    = diff[DataWidth-1:0];
                carryC = diff[DataWidth];
                ovfC   = (opA[DataWidth-1] != opB[DataWidth-1]) &&
                         (diff[DataWidth-1] != opA[DataWidth-1]);
            end
            OP_SUBU:
            begin
                // Carry holds the borrow here
                res    = diff[DataWidth-1:0];
                carryC = diff[DataWidth];
            end

            OP_SLL:  res = opB << shamt;
            OP_SLLV: res = opB << opA[4:0];
            OP_SRA:  res = $signed(opB) >>> shamt;
            OP_SRAV: res = $signed(opB) >>> opA[4:0];
            OP_SRL:  res = opB >> shamt;
            OP_SRLV: res = opB >> opA[4:0];

            OP_AND:  res = opA & opB;
            OP_OR,
            OP_ORI:  res = opA | opB;
            OP_XOR:  res = opA ^ opB;
            OP_NOR:  res = ~(opA | opB);
            // Immediate arrives already shifted into the upper half
            OP_LUI:  res = opB;

            OP_MOVN:
            begin
                res    = opA;
                moveOk = (opB != '0);
            end
            OP_MOVZ:
            begin
                res    = opA;
                moveOk = (opB == '0);
            end

            OP_SLT,
            OP_SLTI:
                res = {{(DataWidth-1){1'b0}}, ($signed(opA) < $signed(opB))};
            OP_SLTU:
                res = {{(DataWidth-1){1'b0}}, (opA < opB)};

            default:
                res = '0;
        endcase
    end

    // Illegal operations report no flags
    assign zeroC = !isNop && (res == '0);
    assign negC  = !isNop && res[DataWidth-1];

    // Write-back toward the register file and the decoder bypass
    assign wbEn   = opValid && !isNop && moveOk && !ovfC;
    assign wbAddr = destReg;
    assign wbData = res;

    //////////////////////////////
    // Result register
    //////////////////////////////

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            resultValid <= 1'b0;
            written     <= 1'b0;
            illegal     <= 1'b0;
            carry       <= 1'b0;
            zero        <= 1'b0;
            overflow    <= 1'b0;
            negative    <= 1'b0;
        end
        else
        begin
            resultValid <= opValid;
            written     <= wbEn;
            illegal     <= opValid && isNop;
            carry       <= opValid && carryC;
            zero        <= opValid && zeroC;
            overflow    <= opValid && ovfC;
            negative    <= opValid && negC;
        end
    end

    always_ff @(posedge clk)
    begin
        if (opValid)
        begin
            resultData <= res;
            resultReg  <= destReg;
        end
    end

    // A presented operation carries fully known operands and destination
    assert property (@(posedge clk) disable iff (!arstN)
                     opValid |-> !$isunknown({op, opA, opB, shamt, destReg}))
        else $error("Decoded operation has unknown bits while opValid is high");

endmodule

// ==== hw/execCore.sv ====
// Integer execute subsystem top level
// Instruction words go through the operand decoder and the ALU,
// with results written back into the register file

`timescale 1ns/1ps

module execCore
(
    input  logic                             clk,
    input  logic                             arstN,
    input  logic                             instrValid,
    input  logic [aluPkg::InstrWidth-1:0]    instr,
    output logic                             resultValid,
    output logic [aluPkg::DataWidth-1:0]     resultData,
    output logic [aluPkg::RegAddrWidth-1:0]  resultReg,
    output logic                             written,
    output logic                             illegal,
    output logic                             carry,
    output logic                             zero,
    output logic                             overflow,
    output logic                             negative
);
    import aluPkg::*;

    // Register file read ports
    logic [RegAddrWidth-1:0] rsAddr;
    logic [RegAddrWidth-1:0] rtAddr;
    logic [DataWidth-1:0]    rsData;
    logic [DataWidth-1:0]    rtData;

    // Decoded operation
    logic                    opValid;
    aluOpE                   op;
    logic [DataWidth-1:0]    opA;
    logic [DataWidth-1:0]    opB;
    logic [ShamtWidth-1:0]   shamt;
    logic [RegAddrWidth-1:0] destReg;

    // Write-back
    logic                    wbEn;
    logic [RegAddrWidth-1:0] wbAddr;
    logic [DataWidth-1:0]    wbData;

    operandDecode i_operandDecode
    (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instr      (instr),
        .rsData     (rsData),
        .rtData     (rtData),
        .wbEn       (wbEn),
        .wbAddr     (wbAddr),
        .wbData     (wbData),
        .rsAddr     (rsAddr),
        .rtAddr     (rtAddr),
        .opValid    (opValid),
        .op         (op),
        .opA        (opA),
        .opB        (opB),
        .shamt      (shamt),
        .destReg    (destReg)
    );

    regFile i_regFile
    (
        .clk    (clk),
        .arstN  (arstN),
        .rsAddr (rsAddr),
        .rtAddr (rtAddr),
        .wbEn   (wbEn),
        .wbAddr (wbAddr),
        .wbData (wbData),
        .rsData (rsData),
        .rtData (rtData)
    );

    alu i_alu
    (
        .clk         (clk),
        .arstN       (arstN),
        .opValid     (opValid),
        .op          (op),
        .opA         (opA),
        .opB         (opB),
        .shamt       (shamt),
        .destReg     (destReg),
        .wbEn        (wbEn),
        .wbAddr      (wbAddr),
        .wbData      (wbData),
        .resultValid (resultValid),
        .resultData  (resultData),
        .resultReg   (resultReg),
        .written     (written),
        .illegal     (illegal),
        .carry       (carry),
        .zero        (zero),
        .overflow    (overflow),
        .negative    (negative)
    );

endmodule

// ==== sim/execModel.svh ====
// Reference model for the execute subsystem testbench
// Shadow register file in issue order and a per-instruction execute function
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

import aluPkg::*;

// Expected response of one instruction
typedef struct packed {
    logic [31:0] seqNum;
    logic [31:0] issueCycle;
    logic [31:0] data;
    logic [4:0]  dest;
    logic        written;
    logic        illegal;
    logic        carry;
    logic        zero;
    logic        overflow;
    logic        negative;
} expectT;

logic [31:0] shadowRegs [0:31];

function automatic expectT executeInstr(input logic [31:0] word);
    expectT      e;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immS;
    logic [4:0]  amt;
    logic [63:0] wide;
    longint      s;
    logic        cond;
    e    = '0;
    a    = shadowRegs[word[25:21]];
    b    = shadowRegs[word[20:16]];
    immS = {{16{word[15]}}, word[15:0]};
    cond = 1'b1;
    // Variable shifts take the amount from rs, fixed ones from the shamt field
    amt  = (word[2] == 1'b1) ? a[4:0] : word[10:6];
    e.dest = word[15:11];
    if (word[31:26] == OPC_SPECIAL)
    begin
        case (word[5:0])
            FN_ADD:
            begin
                s          = longint'($signed(a)) + longint'($signed(b));
                wide       = {32'h0, a} + {32'h0, b};
                e.data     = a + b;
                e.carry    = wide[32];
                e.overflow = (s > 64'sh7FFFFFFF) || (s < -64'sh80000000);
            end
            FN_ADDU:
            begin
                wide    = {32'h0, a} + {32'h0, b};
                e.data  = a + b;
                e.carry = wide[32];
            end
            FN_SUB:
            begin
                s          = longint'($signed(a)) - longint'($signed(b));
                e.data     = a - b;
                e.carry    = (a < b);
                e.overflow = (s > 64'sh7FFFFFFF) || (s < -64'sh80000000);
            end
            FN_SUBU:
            begin
                // Borrow out of the unsigned subtract
                e.data  = a - b;
                e.carry = (a < b);
            end
            FN_SLL, FN_SLLV: e.data = b << amt;
            FN_SRL, FN_SRLV: e.data = b >> amt;
            FN_SRA, FN_SRAV:
            begin
                wide   = {{32{b[31]}}, b} >> amt;
                e.data = wide[31:0];
            end
            FN_AND:  e.data = a & b;
            FN_OR:   e.data = a | b;
            FN_XOR:  e.data = a ^ b;
            FN_NOR:  e.data = ~(a | b);
            FN_MOVN:
            begin
                e.data = a;
                cond   = (b != 32'h0);
            end
            FN_MOVZ:
            begin
                e.data = a;
                cond   = (b == 32'h0);
            end
            FN_SLT:  e.data = 32'($signed(a) < $signed(b));
            FN_SLTU: e.data = 32'(a < b);
            default: e.illegal = 1'b1;
        endcase
    end
    else
    begin
        case (word[31:26])
            OPC_ADDIU:
            begin
                wide    = {32'h0, a} + {32'h0, immS};
                e.data  = a + immS;
                e.carry = wide[32];
                e.dest  = word[20:16];
            end
            OPC_SLTI:
            begin
                e.data = 32'($signed(a) < $signed(immS));
                e.dest = word[20:16];
            end
            OPC_ORI:
            begin
                e.data = a | {16'h0, word[15:0]};
                e.dest = word[20:16];
            end
            OPC_LUI:
            begin
                e.data = {word[15:0], 16'h0};
                e.dest = word[20:16];
            end
            default: e.illegal = 1'b1;
        endcase
    end
    if (!e.illegal)
    begin
        e.zero     = (e.data == 32'h0);
        e.negative = e.data[31];
        e.written  = cond && !e.overflow;
    end
    // Register 0 stays zero
    if (e.written && (e.dest != 5'd0))
        shadowRegs[e.dest] = e.data;
    return e;
endfunction

`endif

// ==== sim/execCoreTb.sv ====
// Testbench for the integer execute subsystem
// Directed and LCG-driven instruction stream, checked against a reference model

`timescale 1ns/1ps

module execCoreTb;

    `include "execModel.svh"

    localparam int NumRandom = 400;
    // Directed and fill instructions stay under 64
    localparam int NumInstr  = NumRandom + 64;
    // Idle cycles at most double the issue time
    localparam int TimeoutNs = (2 * NumInstr + 50) * 10;

    localparam logic [5:0] FunctList [0:17] = '{
        FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLL, FN_SLLV, FN_SRA, FN_SRAV, FN_SRL,
        FN_SRLV, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_MOVN, FN_MOVZ, FN_SLT, FN_SLTU
    };

    logic        clk;
    logic        arstN;
    logic        instrValid;
    logic [31:0] instr;
    logic        resultValid;
    logic [31:0] resultData;
    logic [4:0]  resultReg;
    logic        written;
    logic        illegal;
    logic        carry;
    logic        zero;
    logic        overflow;
    logic        negative;

    logic [31:0] lcgState;
    logic [31:0] cycleCount = '0;
    logic [4:0]  lastDest;
    int          errorCount;
    int          checkCount;
    int          issued;
    expectT      expectQ [$];

    execCore i_dut
    (
        .clk         (clk),
        .arstN       (arstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .resultValid (resultValid),
        .resultData  (resultData),
        .resultReg   (resultReg),
        .written     (written),
        .illegal     (illegal),
        .carry       (carry),
        .zero        (zero),
        .overflow    (overflow),
        .negative    (negative)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 32'd1;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return {16'h0, lcgState[31:16]};
    endfunction

    function automatic logic [31:0] rType(input logic [5:0] fn, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] opc, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic logic [31:0] randomInstr();
        logic [31:0] kind;
        logic [31:0] r;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sh;
        logic [15:0] imm;
        logic [5:0]  opc;
        kind = nextRandom() % 32'd32;
        r    = nextRandom() % 32'd18;
        rs   = r[4:0];
        r    = nextRandom() % 32'd18;
        rt   = r[4:0];
        r    = nextRandom() % 32'd18;
        rd   = r[4:0];
        r    = nextRandom();
        sh   = r[4:0];
        imm  = r[15:0];
        // Lean on the last destination to exercise the bypass
        r = nextRandom() % 32'd4;
        if (r == 32'd0)
            rs = lastDest;
        r = nextRandom() % 32'd4;
        if (kind < 32'd2)
        begin
            case (r[1:0])
                2'd0:    return rType(FN_JR, rs, 5'd0, 5'd0, 5'd0);
                2'd1:    return rType(FN_JALR, rs, 5'd0, rd, 5'd0);
                2'd2:    return iType(6'h3F, rs, rt, imm);
                default: return rType(6'h01, rs, rt, rd, sh);
            endcase
        end
        else if (kind < 32'd9)
        begin
            case (r[1:0])
                2'd0:    opc = OPC_ADDIU;
                2'd1:    opc = OPC_SLTI;
                2'd2:    opc = OPC_ORI;
                default: opc = OPC_LUI;
            endcase
            lastDest = rt;
            return iType(opc, rs, rt, imm);
        end
        r        = nextRandom() % 32'd18;
        lastDest = rd;
        return rType(FunctList[r[4:0]], rs, rt, rd, sh);
    endfunction

    task automatic issueInstr(input logic [31:0] word);
        expectT e;
        @(posedge clk);
        #1;
        instrValid   = 1'b1;
        instr        = word;
        e            = executeInstr(word);
        e.seqNum     = 32'(issued);
        e.issueCycle = cycleCount;
        expectQ.push_back(e);
        issued++;
    endtask

    // Idle cycle with noise on the instruction bus
    task automatic idleCycle();
        @(posedge clk);
        #1;
        instrValid = 1'b0;
        instr      = nextRandom();
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic compareResult();
        expectT e;
        string  tag;
        e   = expectQ.pop_front();
        tag = $sformatf("instr %0d", e.seqNum);
        checkValue({tag, " latency"}, 32'd2, cycleCount - e.issueCycle);
        checkValue({tag, " resultData"}, e.data, resultData);
        checkValue({tag, " resultReg"}, 32'(e.dest), 32'(resultReg));
        checkValue({tag, " written"}, 32'(e.written), 32'(written));
        checkValue({tag, " illegal"}, 32'(e.illegal), 32'(illegal));
        checkValue({tag, " carry"}, 32'(e.carry), 32'(carry));
        checkValue({tag, " zero"}, 32'(e.zero), 32'(zero));
        checkValue({tag, " overflow"}, 32'(e.overflow), 32'(overflow));
        checkValue({tag, " negative"}, 32'(e.negative), 32'(negative));
    endtask

    //////////////////////////////
    // Result monitor
    //////////////////////////////

    always @(negedge clk)
    begin
        if (!arstN)
        begin
            if (resultValid !== 1'b0)
            begin
                errorCount++;
                $display("resultValid was not low during reset at %0t", $time);
            end
        end
        else if (resultValid === 1'b1)
        begin
            if (expectQ.size() == 0)
            begin
                errorCount++;
                $display("resultValid seen at %0t with no instruction outstanding", $time);
            end
            else
                compareResult();
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial
    begin
        logic [31:0] r;
        instrValid = 1'b0;
        instr      = '0;
        arstN      = 1'b0;
        lcgState   = 32'd66;
        lastDest   = 5'd0;
        errorCount = 0;
        checkCount = 0;
        issued     = 0;
        for (int i = 0; i < 32; i++)
            shadowRegs[i] = '0;
        repeat (3) @(posedge clk);
        #1;
        arstN = 1'b1;

        // First read after reset sees cleared registers
        issueInstr(rType(FN_ADDU, 5'd6, 5'd7, 5'd5, 5'd0));

        // Fill registers 1 to 16, each ORI depends on the LUI just before
        for (int i = 1; i <= 16; i++)
        begin
            r = nextRandom();
            issueInstr(iType(OPC_LUI, 5'd0, 5'(i), r[15:0]));
            r = nextRandom();
            issueInstr(iType(OPC_ORI, 5'(i), 5'(i), r[15:0]));
        end

        // Write to register 0 then read it back
        issueInstr(iType(OPC_ORI, 5'd1, 5'd0, 16'h1234));
        issueInstr(rType(FN_OR, 5'd0, 5'd0, 5'd17, 5'd0));
        // Signed overflow leaves r21 and r24 unchanged
        issueInstr(iType(OPC_LUI, 5'd0, 5'd20, 16'h7FFF));
        issueInstr(rType(FN_ADD, 5'd20, 5'd20, 5'd21, 5'd0));
        issueInstr(rType(FN_OR, 5'd21, 5'd0, 5'd22, 5'd0));
        issueInstr(iType(OPC_LUI, 5'd0, 5'd23, 16'h8000));
        issueInstr(rType(FN_SUB, 5'd23, 5'd20, 5'd24, 5'd0));
        issueInstr(rType(FN_OR, 5'd24, 5'd21, 5'd22, 5'd0));
        // Jumps and an unknown opcode
        issueInstr(rType(FN_JR, 5'd1, 5'd0, 5'd0, 5'd0));
        issueInstr(rType(FN_JALR, 5'd1, 5'd0, 5'd31, 5'd0));
        issueInstr(iType(6'h3F, 5'd1, 5'd2, 16'hBEEF));
        // Back-to-back chain and a variable shift with a wide amount
        issueInstr(rType(FN_ADDU, 5'd1, 5'd2, 5'd25, 5'd0));
        issueInstr(rType(FN_ADDU, 5'd25, 5'd25, 5'd26, 5'd0));
        issueInstr(rType(FN_SLLV, 5'd26, 5'd3, 5'd27, 5'd0));

        for (int i = 0; i < NumRandom; i++)
        begin
            r = nextRandom() % 32'd8;
            if (r == 32'd0)
                idleCycle();
            issueInstr(randomInstr());
        end
        idleCycle();
        while (expectQ.size() != 0)
            @(posedge clk);
        repeat (3) @(posedge clk);

        $display("Summary: %0d instructions, %0d checks, %0d errors",
                 issued, checkCount, errorCount);
        if (errorCount == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(TimeoutNs);
        $display("Timeout after %0d ns with %0d results outstanding",
                 TimeoutNs, expectQ.size());
        $display("Summary: %0d instructions, %0d checks, %0d errors",
                 issued, checkCount, errorCount);
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+sim
common/aluPkg.sv
hw/decode/operandDecode.sv
hw/regFile.sv
hw/alu/alu.sv
hw/execCore.sv
sim/execCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the execCore testbench with Verilator, then check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -sv --top-module execCoreTb -f all.f \
    -Mdir obj_dir -o execCoreSim \
    && ./obj_dir/execCoreSim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "All tests passed" sim.log 2>/dev/null \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }
